/* Makefile */
# Verilator build and run for the PCM sound block

VERILATOR ?= verilator
TOP       ?= snd_tb
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal -j 0
PASS_MSG  ?= === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* sources.f */
verilog/snd_pkg.sv
verilog/snd_regs.sv
verilog/pcm_voice.sv
verilog/pcm_fetch_arb.sv
verilog/snd_mixer.sv
verilog/snd_top.sv
verif/snd_tb_clk.sv
verif/snd_tb.sv

/* verif/snd_tb.sv */
/*
 * PCM sound block testbench
 * host register traffic, a slow sample ROM and a tick-level reference model
 */
`timescale 1ns/1ps
`default_nettype none

module snd_tb;

    localparam int TICK_CYCLES    = 64;
    localparam int TEST_TICKS     = 120;  // summed test lengths, rounded up
    localparam int WATCHDOG_NS    = (16 + TEST_TICKS * TICK_CYCLES) * 10 * 2;
    localparam int LEVEL_GAIN [4] = '{2, 4, 8, 20};  // 4.4 gains per level

    logic               clk;
    logic               rst_n;
    logic               cen_sample;
    logic [7:0]         addr;
    logic [7:0]         wdata;
    logic               wr;
    logic               rd;
    logic [7:0]         rdata;
    logic [18:0]        rom_addr;
    logic               rom_cs;
    logic [7:0]         rom_data;
    logic               rom_ok;
    logic signed [15:0] snd_left;
    logic signed [15:0] snd_right;
    logic               sample;
    logic               peak;

    // reference model
    logic [7:0]         shadow [snd_pkg::NUM_VOICES][9];  // voice registers as written
    logic [7:0]         glob;
    bit                 m_play [snd_pkg::NUM_VOICES];
    int                 m_phase [snd_pkg::NUM_VOICES];
    int                 m_cur [snd_pkg::NUM_VOICES];      // data x volume
    logic signed [15:0] exp_l;
    logic signed [15:0] exp_r;
    logic               exp_peak;
    logic [7:0]         exp_rd;

    int    tick_cnt;
    int    errors;
    int    checks;
    int    tests;
    int    err_mark;
    string test_name;

    snd_tb_clk clk_gen (.clk(clk), .rst_n(rst_n));

    snd_top snd_top_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen_sample (cen_sample),
        .addr       (addr),
        .wdata      (wdata),
        .wr         (wr),
        .rd         (rd),
        .rdata      (rdata),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_data   (rom_data),
        .rom_ok     (rom_ok),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .sample     (sample),
        .peak       (peak)
    );

    function automatic logic [7:0] addr_of(input int v, input int o);
        return {2'b00, v[1:0], o[3:0]};
    endfunction

    function automatic int voice_start(input int v);
        return {13'd0, shadow[v][2][2:0], shadow[v][1], shadow[v][0]};
    endfunction

    function automatic int voice_end(input int v);
        return {13'd0, shadow[v][5][2:0], shadow[v][4], shadow[v][3]};
    endfunction

    // ROM byte at a, signed, times unsigned volume
    function automatic int rom_sample(input int a, input logic [7:0] vol);
        logic [7:0] b;
        int         s;
        int         g;
        b = a[7:0] ^ 8'h5a;
        s = $signed(b);
        g = vol;
        return s * g;
    endfunction

    function automatic logic signed [15:0] clamp16(input int v);
        if (v > 32767) return 16'sh7fff;
        if (v < -32768) return 16'sh8000;
        return 16'(v);
    endfunction

    function automatic logic [7:0] expected_read(input logic [7:0] a);
        int v;
        int o;
        v = a[5:4];
        o = a[3:0];
        if (a == snd_pkg::GLOBAL_ADDR) return {5'd0, glob[2:0]};
        if (a[7:6] != 2'b00 || o > 8) return 8'hff;
        if (o == 2 || o == 5) return {5'd0, shadow[v][o][2:0]};
        if (o == 8) return {4'd0, shadow[v][8][3:1], m_play[v]};  // live play flag
        return shadow[v][o];
    endfunction

    // expected mix from the samples before this tick, then step every voice
    task automatic mix_tick();
        int sl;
        int sr;
        int g;
        int nx;
        int na;
        sl = 0;
        sr = 0;
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            if (shadow[v][8][2]) sl += m_cur[v];
            if (shadow[v][8][3]) sr += m_cur[v];
        end
        g  = glob[2] ? LEVEL_GAIN[glob[1:0]] : 0;
        sl = (sl * g) >>> 4;
        sr = (sr * g) >>> 4;
        exp_peak = sl > 32767 || sl < -32768 || sr > 32767 || sr < -32768;
        exp_l    = clamp16(sl);
        exp_r    = clamp16(sr);
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            if (m_play[v]) begin
                nx = m_phase[v] + int'(shadow[v][6]);
                na = voice_start(v) + (nx >> 4);
                if (na > voice_end(v)) begin
                    if (shadow[v][8][1]) begin  // loop back to the start
                        m_phase[v] = 0;
                        m_cur[v]   = rom_sample(voice_start(v), shadow[v][7]);
                    end else begin
                        m_play[v] = 1'b0;
                        m_cur[v]  = 0;
                    end
                end else begin
                    m_phase[v] = nx;
                    m_cur[v]   = rom_sample(na, shadow[v][7]);
                end
            end
        end
    endtask

    // key-on needs its fetch done before the next tick, so only early in the period
    task automatic write_reg(input logic [7:0] a, input logic [7:0] d);
        int lim;
        int v;
        lim = (a[7:6] == 2'b00 && a[3:0] == 4'd8 && d[0]) ? 20 : 58;
        v   = a[5:4];
        @(negedge clk);
        while (tick_cnt < 2 || tick_cnt > lim) @(negedge clk);
        addr  = a;
        wdata = d;
        wr    = 1'b1;
        if (a == snd_pkg::GLOBAL_ADDR) begin
            glob = d;
        end else if (a[7:6] == 2'b00 && a[3:0] <= 4'd8) begin
            shadow[v][a[3:0]] = d;
            if (a[3:0] == 4'd8) begin
                m_play[v]  = d[0];
                m_phase[v] = 0;
                m_cur[v]   = d[0] ? rom_sample(voice_start(v), shadow[v][7]) : 0;
            end
        end
        @(negedge clk);
        wr = 1'b0;
    endtask

    task automatic read_check(input logic [7:0] a);
        @(negedge clk);
        while (tick_cnt < 2 || tick_cnt > 58) @(negedge clk);
        addr   = a;
        rd     = 1'b1;
        exp_rd = expected_read(a);
        @(negedge clk);
        rd = 1'b0;
    endtask

    task automatic setup_voice(input int v, input int st, input int en,
                               input logic [7:0] step, input logic [7:0] vol);
        write_reg(addr_of(v, 0), 8'(st));
        write_reg(addr_of(v, 1), 8'(st >> 8));
        write_reg(addr_of(v, 2), 8'(st >> 16));
        write_reg(addr_of(v, 3), 8'(en));
        write_reg(addr_of(v, 4), 8'(en >> 8));
        write_reg(addr_of(v, 5), 8'(en >> 16));
        write_reg(addr_of(v, 6), step);
        write_reg(addr_of(v, 7), vol);
    endtask

    task automatic wait_samples(input int n);
        repeat (n) @(posedge sample);
    endtask

    task automatic finish_test();
        $display("%-14s %s, %0d errors", test_name,
                 errors == err_mark ? "ok" : "failed", errors - err_mark);
        tests++;
        err_mark = errors;
    endtask

    a_mix: assert property (@(posedge clk) disable iff (!rst_n)
        sample |-> snd_left == exp_l && snd_right == exp_r && peak == exp_peak)
        else begin
            $display("ERR %s: mix expected %0d/%0d peak %0b actual %0d/%0d peak %0b",
                     test_name, exp_l, exp_r, exp_peak, snd_left, snd_right, peak);
            errors++;
        end

    // sample pulses exactly one cycle after each tick
    a_sample: assert property (@(posedge clk) disable iff (!rst_n)
        sample == $past(cen_sample))
        else begin
            $display("%s: sample pulse not one cycle after the sample tick", test_name);
            errors++;
        end

    a_rdata: assert property (@(posedge clk) disable iff (!rst_n) rd |=> rdata == exp_rd)
        else begin
            $display("ERR %s: rdata at %02h expected %02h actual %02h",
                     test_name, addr, exp_rd, rdata);
            errors++;
        end

    always @(posedge clk) begin
        if (rst_n && sample) checks++;
        if (rst_n && rd) checks++;
    end

    // sample ROM, low address byte xor 5a after 0 to 5 wait cycles
    initial begin
        rom_ok   = 1'b0;
        rom_data = 8'h00;
        forever begin
            @(negedge clk);
            if (rom_cs && !rom_ok) begin
                repeat ($urandom_range(5, 0)) @(negedge clk);
                rom_data = rom_addr[7:0] ^ 8'h5a;
                rom_ok   = 1'b1;
            end else begin
                rom_ok = 1'b0;
            end
        end
    end

    // sample tick every 64 cycles, model steps with it
    initial begin
        cen_sample = 1'b0;
        tick_cnt   = 0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            tick_cnt   = (tick_cnt == TICK_CYCLES - 1) ? 0 : tick_cnt + 1;
            cen_sample = tick_cnt == TICK_CYCLES - 1;
            if (cen_sample) mix_tick();
        end
    end

    initial begin
        #WATCHDOG_NS;
        $display("watchdog: run did not finish within %0d ns", WATCHDOG_NS);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        logic [7:0] d;
        addr      = 8'h00;
        wdata     = 8'h00;
        wr        = 1'b0;
        rd        = 1'b0;
        errors    = 0;
        checks    = 0;
        tests     = 0;
        err_mark  = 0;
        exp_l     = '0;
        exp_r     = '0;
        exp_peak  = 1'b0;
        exp_rd    = 8'h00;
        glob      = 8'h04;  // enabled, level 0
        test_name = "reset";
        foreach (shadow[i, j]) shadow[i][j] = 8'h00;
        foreach (m_play[i]) begin
            m_play[i]  = 1'b0;
            m_phase[i] = 0;
            m_cur[i]   = 0;
        end
        void'($urandom(32'he228a55b));
        @(posedge rst_n);
        @(negedge clk);
        assert (!rom_cs && !sample && !peak && snd_left == 0 && snd_right == 0)
            else begin
                $display("reset state wrong: ROM select, sample, peak or outputs not idle");
                errors++;
            end

        test_name = "readback";
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            for (int o = 0; o < 9; o++) begin
                d = 8'($urandom);
                if (o == 8) d[0] = 1'b0;  // keep the voice silent
                write_reg(addr_of(v, o), d);
            end
        end
        write_reg(snd_pkg::GLOBAL_ADDR, 8'($urandom));
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) begin
            for (int o = 0; o < 9; o++) read_check(addr_of(v, o));
        end
        read_check(snd_pkg::GLOBAL_ADDR);
        read_check(8'h09);
        read_check(8'h3f);
        read_check(8'h41);
        read_check(8'h80);
        read_check(8'hff);
        setup_voice(2, 'h10, 'h20, 8'h10, 8'h10);
        write_reg(addr_of(2, 8), 8'h03);
        read_check(addr_of(2, 8));
        write_reg(addr_of(2, 8), 8'h02);
        read_check(addr_of(2, 8));
        write_reg(snd_pkg::GLOBAL_ADDR, 8'h06);
        finish_test();

        test_name = "single_voice";
        setup_voice(0, 'h100, 'h11f, 8'h10, 8'h40);
        write_reg(addr_of(0, 8), 8'h05);  // play, pan left
        wait_samples(12);
        write_reg(addr_of(0, 8), 8'h04);
        finish_test();

        test_name = "half_step";
        setup_voice(1, 'h2000, 'h2005, 8'h08, 8'h7f);
        write_reg(addr_of(1, 8), 8'h09);  // play, pan right, no loop
        wait_samples(16);
        read_check(addr_of(1, 8));
        wait_samples(2);
        finish_test();

        test_name = "loop_shared";
        write_reg(snd_pkg::GLOBAL_ADDR, 8'h05);
        setup_voice(0, 'h0400, 'h0406, 8'h10, 8'h50);
        setup_voice(1, 'h1230, 'h1238, 8'h18, 8'h60);
        setup_voice(2, 'h0010, 'h0014, 8'h08, 8'h70);
        setup_voice(3, 'h7ff0, 'h7ff9, 8'h30, 8'hff);
        write_reg(addr_of(0, 8), 8'h07);
        write_reg(addr_of(1, 8), 8'h0b);
        write_reg(addr_of(2, 8), 8'h0f);
        write_reg(addr_of(3, 8), 8'h07);
        wait_samples(24);
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) write_reg(addr_of(v, 8), 8'h00);
        wait_samples(2);
        finish_test();

        test_name = "level_peak";
        setup_voice(0, 'h0300, 'h030f, 8'h10, 8'h30);
        write_reg(addr_of(0, 8), 8'h0f);
        for (int lvl = 0; lvl < 4; lvl++) begin
            write_reg(snd_pkg::GLOBAL_ADDR, 8'h04 | 8'(lvl));
            wait_samples(3);
        end
        write_reg(snd_pkg::GLOBAL_ADDR, 8'h03);  // pcm off
        wait_samples(3);
        write_reg(addr_of(0, 8), 8'h0e);
        wait_samples(2);
        setup_voice(0, 'h00da, 'h00da, 8'h10, 8'hff);  // byte 80
        setup_voice(1, 'h00da, 'h00da, 8'h10, 8'hff);
        setup_voice(2, 'h0125, 'h0125, 8'h10, 8'hff);  // byte 7f
        setup_voice(3, 'h0125, 'h0125, 8'h10, 8'hff);
        write_reg(snd_pkg::GLOBAL_ADDR, 8'h07);
        write_reg(addr_of(0, 8), 8'h07);
        write_reg(addr_of(1, 8), 8'h07);
        write_reg(addr_of(2, 8), 8'h0b);
        write_reg(addr_of(3, 8), 8'h0b);
        wait_samples(4);
        for (int v = 0; v < snd_pkg::NUM_VOICES; v++) write_reg(addr_of(v, 8), 8'h00);
        wait_samples(2);
        finish_test();

        test_name = "key_off";
        write_reg(snd_pkg::GLOBAL_ADDR, 8'h06);
        setup_voice(0, 'h0500, 'h0510, 8'h10, 8'h40);
        setup_voice(1, 'h0600, 'h0610, 8'h10, 8'h40);
        write_reg(addr_of(0, 8), 8'h07);
        write_reg(addr_of(1, 8), 8'h07);
        wait_samples(3);
        repeat (30) @(negedge clk);
        write_reg(addr_of(1, 8), 8'h06);  // still panned left, play cleared
        wait_samples(3);
        write_reg(addr_of(0, 8), 8'h06);
        wait_samples(2);
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verif/snd_tb_clk.sv */
/*
 * Testbench clock and reset, 10 ns period, reset held 16 cycles
 */
`timescale 1ns/1ps
`default_nettype none

module snd_tb_clk (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;  // released away from the active edge
    end

endmodule

`default_nettype wire

/* verilog/pcm_fetch_arb.sv */
/*
 * Sample ROM fetch arbiter
 * round-robin among voice requests, one fetch in flight,
 * address held until rom_ok, one idle cycle between fetches
 */
`timescale 1ns/1ps
`default_nettype none

module pcm_fetch_arb (
    input  wire logic                                        clk,
    input  wire logic                                        rst_n,
    input  wire snd_pkg::rom_req_t [snd_pkg::NUM_VOICES-1:0] reqs,
    output      logic [snd_pkg::NUM_VOICES-1:0]              fetch_done,
    output      logic [snd_pkg::PCM_AW-1:0]                  rom_addr,
    output      logic                                        rom_cs,
    input  wire logic                                        rom_ok
);

    logic [snd_pkg::VOICE_W-1:0] ptr;   // first voice to look at
    logic [snd_pkg::VOICE_W-1:0] gnt;
    logic [snd_pkg::VOICE_W-1:0] pick;
    logic                        any_req;

    // lowest offset from ptr wins, so scan downwards
    always_comb begin
        logic [snd_pkg::VOICE_W-1:0] idx;
        any_req = 1'b0;
        pick    = ptr;
        for (int i = snd_pkg::NUM_VOICES - 1; i >= 0; i--) begin
            idx = ptr + snd_pkg::VOICE_W'(i);
            if (reqs[idx].req) begin
                pick    = idx;
                any_req = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rom_cs <= 1'b0;
            gnt    <= '0;
            ptr    <= '0;
        end else if (rom_cs) begin
            if (rom_ok) begin
                rom_cs <= 1'b0;        // gap cycle
                ptr    <= gnt + 1'b1;
            end
        end else if (any_req) begin
            rom_cs <= 1'b1;
            gnt    <= pick;
        end
    end

    always_ff @(posedge clk) begin
        if (!rom_cs && any_req) rom_addr <= reqs[pick].addr;
    end

    // data is sampled by the voice on this same edge
    always_comb begin
        fetch_done = '0;
        if (rom_cs && rom_ok) fetch_done[gnt] = 1'b1;
    end

    a_done_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(fetch_done));

    a_addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rom_cs && !rom_ok |=> rom_cs && $stable(rom_addr));

endmodule

`default_nettype wire

/* verilog/pcm_voice.sv */
/*
 * PCM voice
 * 4.4 phase stepping through the sample ROM, end wrap or stop,
 * one byte fetched per address change, scaled by volume
 */
`timescale 1ns/1ps
`default_nettype none

module pcm_voice (
    input  wire logic                     clk,
    input  wire logic                     rst_n,
    input  wire logic                     cen_sample,
    input  wire snd_pkg::voice_cfg_t      cfg,
    input  wire logic                     key_on,
    input  wire logic                     key_off,
    output      snd_pkg::rom_req_t        req,
    input  wire logic                     fetch_done,
    input  wire logic [7:0]               rom_data,
    output      snd_pkg::voice_out_t      vout
);

    snd_pkg::voice_state_e               state;
    logic [snd_pkg::PHASE_W-1:0]         phase;
    logic [snd_pkg::PHASE_W-1:0]         phase_nx;
    logic [snd_pkg::PCM_AW-1:0]          addr_now;
    logic [snd_pkg::PCM_AW-1:0]          addr_nx;
    logic                                int_moved;  // integer part changes
    logic signed [16:0]                  prod;
    logic signed [15:0]                  sample_q;

    assign phase_nx  = phase + snd_pkg::PHASE_W'(cfg.step);
    assign addr_now  = cfg.start_addr + phase[snd_pkg::PHASE_W-1:snd_pkg::PHASE_FW];
    assign addr_nx   = cfg.start_addr + phase_nx[snd_pkg::PHASE_W-1:snd_pkg::PHASE_FW];
    assign int_moved = phase_nx[snd_pkg::PHASE_W-1:snd_pkg::PHASE_FW]
                       != phase[snd_pkg::PHASE_W-1:snd_pkg::PHASE_FW];

    // signed byte times unsigned volume, always fits 16 bits
    assign prod = $signed(rom_data) * $signed({1'b0, cfg.volume});

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= snd_pkg::IDLE;
            phase    <= '0;
            sample_q <= '0;
        end else if (key_off) begin
            state    <= snd_pkg::IDLE;  // silent from the next tick on
            sample_q <= '0;
        end else if (key_on) begin
            phase <= '0;
            state <= snd_pkg::FETCH;
        end else begin
            case (state)
                snd_pkg::FETCH: begin
                    if (fetch_done) begin
                        sample_q <= prod[15:0];
                        state    <= snd_pkg::PLAY;
                    end
                end
                snd_pkg::PLAY: begin
                    if (cen_sample) begin
                        if (addr_nx > cfg.end_addr) begin
                            if (cfg.loop) begin
                                phase <= '0;
                                state <= snd_pkg::FETCH;
                            end else begin
                                state    <= snd_pkg::IDLE;
                                sample_q <= '0;
                            end
                        end else begin
                            phase <= phase_nx;
                            if (int_moved) state <= snd_pkg::FETCH;
                        end
                    end
                end
                default: ;  // idle waits for key_on
            endcase
        end
    end

    assign req.req      = state == snd_pkg::FETCH;
    assign req.addr     = addr_now;  // phase frozen while fetching
    assign vout.sample  = sample_q;
    assign vout.playing = state != snd_pkg::IDLE;

    // never reads past the end of the sample
    a_req_in_range: assert property (@(posedge clk) disable iff (!rst_n)
        req.req |-> req.addr <= cfg.end_addr);

endmodule

`default_nettype wire

/* verilog/snd_mixer.sv */
/*
 * Stereo PCM mixer
 * per-voice pan, global 4.4 level gain, 16-bit saturation and peak flag
 */
`timescale 1ns/1ps
`default_nettype none

module snd_mixer (
    input  wire logic                                          clk,
    input  wire logic                                          rst_n,
    input  wire logic                                          cen_sample,
    input  wire snd_pkg::voice_out_t [snd_pkg::NUM_VOICES-1:0] vouts,
    input  wire snd_pkg::voice_cfg_t [snd_pkg::NUM_VOICES-1:0] cfg,
    input  wire logic [1:0]                                    level,
    input  wire logic                                          pcm_en,
    output      logic signed [15:0]                            snd_left,
    output      logic signed [15:0]                            snd_right,
    output      logic                                          sample,
    output      logic                                          peak
);

    logic [7:0]         gain;
    logic signed [17:0] sum_l;   // two bits of headroom for four voices
    logic signed [17:0] sum_r;
    logic signed [26:0] prod_l;
    logic signed [26:0] prod_r;
    logic [16:0]        sat_l;   // {overflow, value}
    logic [16:0]        sat_r;

    function automatic logic [16:0] sat16(input logic signed [22:0] v);
        logic [16:0] res;
        if (v > 23'sd32767) res = {1'b1, 16'h7fff};
        else if (v < -23'sd32768) res = {1'b1, 16'h8000};
        else res = {1'b0, v[15:0]};
        return res;
    endfunction

    assign gain = pcm_en ? snd_pkg::PCM_GAIN[level] : 8'h00;

    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < snd_pkg::NUM_VOICES; i++) begin
            if (cfg[i].pan_l) sum_l = sum_l + 18'(vouts[i].sample);
            if (cfg[i].pan_r) sum_r = sum_r + 18'(vouts[i].sample);
        end
    end

    assign prod_l = sum_l * $signed({1'b0, gain});
    assign prod_r = sum_r * $signed({1'b0, gain});
    assign sat_l  = sat16(23'(prod_l >>> 4));  // drop the 4.4 fraction
    assign sat_r  = sat16(23'(prod_r >>> 4));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            snd_left  <= '0;
            snd_right <= '0;
            sample    <= 1'b0;
            peak      <= 1'b0;
        end else begin
            sample <= cen_sample;
            if (cen_sample) begin
                snd_left  <= sat_l[15:0];
                snd_right <= sat_r[15:0];
                peak      <= sat_l[16] | sat_r[16];
            end
        end
    end

    a_sample_after_cen: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(sample) |-> $past(cen_sample));

endmodule

`default_nettype wire

/* verilog/snd_pkg.sv */
/*
 * PCM sound block shared definitions
 * sizes, host register map, level gains, voice and ROM request types
 */
`default_nettype none

package snd_pkg;

    localparam int NUM_VOICES = 4;
    localparam int VOICE_W    = $clog2(NUM_VOICES);
    localparam int PCM_AW     = 19;                  // sample ROM address width
    localparam int PHASE_FW   = 4;                   // fractional phase bits
    localparam int PHASE_W    = PCM_AW + PHASE_FW;

    localparam logic [7:0] GLOBAL_ADDR = 8'h40;

    // 4.4 gains indexed by the global level
    localparam logic [7:0] PCM_GAIN [4] = '{8'h02, 8'h04, 8'h08, 8'h14};

    // voice register offsets, addr[3:0]
    typedef enum logic [3:0] {
        START_L = 4'd0,
        START_M = 4'd1,
        START_H = 4'd2,  // 3 bits used
        END_L   = 4'd3,
        END_M   = 4'd4,
        END_H   = 4'd5,
        STEP    = 4'd6,  // 4.4 increment
        VOLUME  = 4'd7,
        CTRL    = 4'd8   // play, loop, pan left, pan right
    } reg_off_e;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        PLAY
    } voice_state_e;

    typedef struct packed {
        logic [PCM_AW-1:0] start_addr;
        logic [PCM_AW-1:0] end_addr;
        logic [7:0]        step;
        logic [7:0]        volume;
        logic              loop;
        logic              pan_l;
        logic              pan_r;
    } voice_cfg_t;

    typedef struct packed {
        logic signed [15:0] sample;   // data x volume
        logic               playing;
    } voice_out_t;

    typedef struct packed {
        logic              req;
        logic [PCM_AW-1:0] addr;
    } rom_req_t;

endpackage

`default_nettype wire

/* verilog/snd_regs.sv */
/*
 * Sound register block
 * host decode, per-voice configuration, global level and key pulses
 */
`timescale 1ns/1ps
`default_nettype none

module snd_regs (
    input  wire logic                                              clk,
    input  wire logic                                              rst_n,
    input  wire logic [7:0]                                        addr,
    input  wire logic [7:0]                                        wdata,
    input  wire logic                                              wr,
    input  wire logic                                              rd,
    output      logic [7:0]                                        rdata,
    input  wire snd_pkg::voice_out_t [snd_pkg::NUM_VOICES-1:0]     voice_stat,
    output      snd_pkg::voice_cfg_t [snd_pkg::NUM_VOICES-1:0]     cfg,
    output      logic [snd_pkg::NUM_VOICES-1:0]                    key_on,
    output      logic [snd_pkg::NUM_VOICES-1:0]                    key_off,
    output      logic [1:0]                                        level,
    output      logic                                              pcm_en
);

    logic [snd_pkg::VOICE_W-1:0] vsel;
    snd_pkg::reg_off_e           off;
    logic                        voice_hit;  // addresses 00-3f
    logic                        glob_hit;
    logic [7:0]                  rd_mux;

    assign vsel      = addr[5:4];
    assign off       = snd_pkg::reg_off_e'(addr[3:0]);
    assign voice_hit = addr[7:6] == 2'b00;
    assign glob_hit  = addr == snd_pkg::GLOBAL_ADDR;

    // key pulses fire with the CTRL write itself
    always_comb begin
        key_on  = '0;
        key_off = '0;
        if (wr && voice_hit && off == snd_pkg::CTRL) begin
            key_on[vsel]  = wdata[0];
            key_off[vsel] = ~wdata[0];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg    <= '0;
            level  <= 2'd0;
            pcm_en <= 1'b1;
        end else if (wr) begin
            if (glob_hit) begin
                level  <= wdata[1:0];
                pcm_en <= wdata[2];
            end else if (voice_hit) begin
                case (off)
                    snd_pkg::START_L: cfg[vsel].start_addr[7:0]   <= wdata;
                    snd_pkg::START_M: cfg[vsel].start_addr[15:8]  <= wdata;
                    snd_pkg::START_H: cfg[vsel].start_addr[18:16] <= wdata[2:0];
                    snd_pkg::END_L:   cfg[vsel].end_addr[7:0]     <= wdata;
                    snd_pkg::END_M:   cfg[vsel].end_addr[15:8]    <= wdata;
                    snd_pkg::END_H:   cfg[vsel].end_addr[18:16]   <= wdata[2:0];
                    snd_pkg::STEP:    cfg[vsel].step              <= wdata;
                    snd_pkg::VOLUME:  cfg[vsel].volume            <= wdata;
                    snd_pkg::CTRL: begin
                        cfg[vsel].loop  <= wdata[1];
                        cfg[vsel].pan_l <= wdata[2];
                        cfg[vsel].pan_r <= wdata[3];
                    end
                    default: ;  // holes in the map
                endcase
            end
        end
    end

    always_comb begin
        rd_mux = 8'hff;
        if (glob_hit) begin
            rd_mux = {5'd0, pcm_en, level};
        end else if (voice_hit) begin
            case (off)
                snd_pkg::START_L: rd_mux = cfg[vsel].start_addr[7:0];
                snd_pkg::START_M: rd_mux = cfg[vsel].start_addr[15:8];
                snd_pkg::START_H: rd_mux = {5'd0, cfg[vsel].start_addr[18:16]};
                snd_pkg::END_L:   rd_mux = cfg[vsel].end_addr[7:0];
                snd_pkg::END_M:   rd_mux = cfg[vsel].end_addr[15:8];
                snd_pkg::END_H:   rd_mux = {5'd0, cfg[vsel].end_addr[18:16]};
                snd_pkg::STEP:    rd_mux = cfg[vsel].step;
                snd_pkg::VOLUME:  rd_mux = cfg[vsel].volume;
                snd_pkg::CTRL:    rd_mux = {4'd0, cfg[vsel].pan_r, cfg[vsel].pan_l,
                                            cfg[vsel].loop, voice_stat[vsel].playing};
                default:          rd_mux = 8'hff;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) rdata <= 8'd0;
        else if (rd) rdata <= rd_mux;  // valid the cycle after rd
    end

    a_key_excl: assert property (@(posedge clk) disable iff (!rst_n)
        (key_on & key_off) == '0);

endmodule

`default_nettype wire

/* verilog/snd_top.sv */
/*
 * PCM sound block top level
 * register map, four voices on a shared sample ROM, stereo mixer
 */
`timescale 1ns/1ps
`default_nettype none

module snd_top (
    input  wire logic                         clk,
    input  wire logic                         rst_n,
    input  wire logic                         cen_sample,
    input  wire logic [7:0]                   addr,
    input  wire logic [7:0]                   wdata,
    input  wire logic                         wr,
    input  wire logic                         rd,
    output      logic [7:0]                   rdata,
    output      logic [snd_pkg::PCM_AW-1:0]   rom_addr,
    output      logic                         rom_cs,
    input  wire logic [7:0]                   rom_data,
    input  wire logic                         rom_ok,
    output      logic signed [15:0]           snd_left,
    output      logic signed [15:0]           snd_right,
    output      logic                         sample,
    output      logic                         peak
);

    snd_pkg::voice_cfg_t [snd_pkg::NUM_VOICES-1:0] cfg;
    snd_pkg::voice_out_t [snd_pkg::NUM_VOICES-1:0] vouts;
    snd_pkg::rom_req_t   [snd_pkg::NUM_VOICES-1:0] reqs;
    logic [snd_pkg::NUM_VOICES-1:0]                key_on;
    logic [snd_pkg::NUM_VOICES-1:0]                key_off;
    logic [snd_pkg::NUM_VOICES-1:0]                fetch_done;
    logic [1:0]                                    level;
    logic                                          pcm_en;

    snd_regs u_regs (
        .clk        (clk),
        .rst_n      (rst_n),
        .addr       (addr),
        .wdata      (wdata),
        .wr         (wr),
        .rd         (rd),
        .rdata      (rdata),
        .voice_stat (vouts),
        .cfg        (cfg),
        .key_on     (key_on),
        .key_off    (key_off),
        .level      (level),
        .pcm_en     (pcm_en)
    );

    for (genvar i = 0; i < snd_pkg::NUM_VOICES; i++) begin : g_voice
        pcm_voice u_voice (
            .clk        (clk),
            .rst_n      (rst_n),
            .cen_sample (cen_sample),
            .cfg        (cfg[i]),
            .key_on     (key_on[i]),
            .key_off    (key_off[i]),
            .req        (reqs[i]),
            .fetch_done (fetch_done[i]),
            .rom_data   (rom_data),       // shared, only the granted voice takes it
            .vout       (vouts[i])
        );
    end

    pcm_fetch_arb u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .reqs       (reqs),
        .fetch_done (fetch_done),
        .rom_addr   (rom_addr),
        .rom_cs     (rom_cs),
        .rom_ok     (rom_ok)
    );

    snd_mixer u_mixer (
        .clk        (clk),
        .rst_n      (rst_n),
        .cen_sample (cen_sample),
        .vouts      (vouts),
        .cfg        (cfg),
        .level      (level),
        .pcm_en     (pcm_en),
        .snd_left   (snd_left),
        .snd_right  (snd_right),
        .sample     (sample),
        .peak       (peak)
    );

endmodule

`default_nettype wire
